/* dnn_weights.hex */
// one signed 16-bit Q8.8 word per line, in hex
// per neuron: bias, then one weight per input in input order
// hidden layer
0040
0100
0080
0040
0180
ff80
0020
0140
0100
0060
0000
00c0
0010
01a0
0100
0100
0100
0100
0030
0050
// output layer, classes 1 and 3 share the largest bias
0080
0100
ff00
0080
ffc0
0200
ff80
0040
ff00
0100
0100
0040
0100
0080
fe80
0200
ffc0
ff80
0100
0040

/* logic/argmax_unit.sv */
`default_nettype none

module argmax_unit import dnn_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   score_valid,
    input  acc_t   score,
    input  class_t score_idx,
    output logic   out_valid,
    output class_t out_class
);

    acc_t best_q;
    class_t best_idx_q;
    logic take_new;
    logic last_score;

    // strictly greater only, so ties keep the lower index
    assign take_new = score_valid && ((score_idx == '0) || (score > best_q));
    assign last_score = score_valid && (score_idx == class_t'(N_OUT - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            best_q <= '0;
            best_idx_q <= '0;
            out_valid <= 1'b0;
            out_class <= '0;
        end else begin
            if (take_new) begin
                best_q <= score;
                best_idx_q <= score_idx;
            end
            out_valid <= last_score;
            if (last_score) begin
                out_class <= take_new ? score_idx : best_idx_q;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/dnn_pkg.sv */
`default_nettype none

package dnn_pkg;

    // network geometry
    localparam int N_IN = 4;
    localparam int N_HID = 4;
    localparam int N_OUT = 4;
    localparam int FEATS_PER_BEAT = 2;

    // signed Q8.8 values
    localparam int FEAT_W = 16;
    localparam int FRAC_BITS = 8;
    localparam int ACC_W = 32;

    // per layer, each neuron has a bias and then its weights
    localparam int ROM_DEPTH = 40;
    localparam string ROM_FILE = "dnn_weights.hex";

    typedef logic signed [FEAT_W-1:0] feat_t;
    typedef logic signed [15:0] weight_t;
    typedef logic signed [ACC_W-1:0] acc_t;
    typedef logic [1:0] class_t;
    typedef logic [5:0] rom_addr_t;
    typedef logic [$clog2(N_IN)-1:0] act_sel_t;

endpackage

`default_nettype wire

/* logic/dnn_top.sv */
`default_nettype none

module dnn_top import dnn_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  feat_t [FEATS_PER_BEAT-1:0]  in_data,
    output logic                        in_credit,
    output logic                        out_valid,
    output class_t                      out_class
);

    logic frame_ready;
    logic frame_take;
    feat_t [N_IN-1:0] frame_feats;
    rom_addr_t rom_addr;
    logic score_valid;
    acc_t score;
    class_t score_idx;

    mac_if mac_bus ();

    frame_buffer frame_buffer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .frame_take  (frame_take),
        .in_credit   (in_credit),
        .frame_ready (frame_ready),
        .frame_feats (frame_feats)
    );

    weight_rom weight_rom_i (
        .clk      (clk),
        .rom_addr (rom_addr),
        .rom_word (mac_bus.rom_word)
    );

    layer_sequencer layer_sequencer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_ready (frame_ready),
        .frame_take  (frame_take),
        .rom_addr    (rom_addr),
        .mac         (mac_bus.seq)
    );

    neuron_mac neuron_mac_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_take  (frame_take),
        .frame_feats (frame_feats),
        .mac         (mac_bus.mac),
        .score_valid (score_valid),
        .score       (score),
        .score_idx   (score_idx)
    );

    argmax_unit argmax_unit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .score_valid (score_valid),
        .score       (score),
        .score_idx   (score_idx),
        .out_valid   (out_valid),
        .out_class   (out_class)
    );

endmodule

`default_nettype wire

/* logic/frame_buffer.sv */
`default_nettype none

module frame_buffer import dnn_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  feat_t [FEATS_PER_BEAT-1:0]  in_data,
    input  logic                        frame_take,
    output logic                        in_credit,
    output logic                        frame_ready,
    output feat_t [N_IN-1:0]            frame_feats
);

    localparam int BEATS = N_IN / FEATS_PER_BEAT;
    localparam int BEAT_W = (BEATS > 1) ? $clog2(BEATS) : 1;

    logic [BEAT_W-1:0] beat_q;
    logic boot_q;
    logic last_beat;

    assign last_beat = in_valid && (beat_q == BEAT_W'(BEATS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_q <= '0;
            boot_q <= 1'b1;
            in_credit <= 1'b0;
            frame_ready <= 1'b0;
        end else begin
            boot_q <= 1'b0;
            // one credit after reset, then one per freed buffer
            in_credit <= boot_q || frame_take;
            if (in_valid) begin
                beat_q <= last_beat ? '0 : beat_q + 1'b1;
            end
            if (frame_take) begin
                frame_ready <= 1'b0;
            end
            if (last_beat) begin
                frame_ready <= 1'b1;
            end
        end
    end

    // newest beat enters at the top, older features move down
    always_ff @(posedge clk) begin
        if (in_valid) begin
            frame_feats <= {in_data, frame_feats[N_IN-1:FEATS_PER_BEAT]};
        end
    end

endmodule

`default_nettype wire

/* logic/layer_sequencer.sv */
`default_nettype none

module layer_sequencer import dnn_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      frame_ready,
    output logic      frame_take,
    output rom_addr_t rom_addr,
    mac_if.seq        mac
);

    localparam int WORD_W = $clog2(N_IN + 1);

    typedef enum logic [1:0] {
        IDLE,
        HIDDEN,
        OUTPUT
    } state_t;

    state_t state_q;
    class_t neuron_q;
    logic [WORD_W-1:0] word_q;
    rom_addr_t addr_q;

    logic active;
    logic last_word;
    logic last_neuron;
    logic frame_end;

    assign active = (state_q != IDLE);
    assign last_word = (word_q == WORD_W'(N_IN));
    assign last_neuron = (state_q == HIDDEN) ? (neuron_q == class_t'(N_HID - 1))
                                             : (neuron_q == class_t'(N_OUT - 1));
    assign frame_end = (state_q == OUTPUT) && last_word && last_neuron;

    assign frame_take = (state_q == IDLE) && frame_ready;
    assign rom_addr = addr_q;

    // word 0 is the bias, words 1..N_IN the weights
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            neuron_q <= '0;
            word_q <= '0;
            addr_q <= '0;
        end else if (state_q == IDLE) begin
            if (frame_ready) begin
                state_q <= HIDDEN;
                neuron_q <= '0;
                word_q <= '0;
                addr_q <= '0;
            end
        end else begin
            // ROM is laid out in walk order
            addr_q <= frame_end ? '0 : addr_q + 1'b1;
            if (!last_word) begin
                word_q <= word_q + 1'b1;
            end else begin
                word_q <= '0;
                if (!last_neuron) begin
                    neuron_q <= neuron_q + 1'b1;
                end else begin
                    neuron_q <= '0;
                    state_q <= (state_q == HIDDEN) ? OUTPUT : IDLE;
                end
            end
        end
    end

    // one cycle behind the address, lined up with rom_word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mac.acc_clear <= 1'b0;
            mac.bias_load <= 1'b0;
            mac.mac_en <= 1'b0;
            mac.act_sel <= '0;
            mac.layer2 <= 1'b0;
            mac.neuron_done <= 1'b0;
            mac.neuron_idx <= '0;
        end else begin
            mac.acc_clear <= frame_end;
            mac.bias_load <= active && (word_q == '0);
            mac.mac_en <= active && (word_q != '0);
            mac.act_sel <= act_sel_t'(word_q - 1'b1);
            mac.layer2 <= (state_q == OUTPUT);
            mac.neuron_done <= active && last_word;
            mac.neuron_idx <= neuron_q;
        end
    end

endmodule

`default_nettype wire

/* logic/mac_if.sv */
`default_nettype none

interface mac_if import dnn_pkg::*; ();

    logic acc_clear;
    logic bias_load;
    logic mac_en;
    act_sel_t act_sel;
    logic layer2;
    logic neuron_done;
    class_t neuron_idx;

    // ROM output, aligned with the delayed controls
    weight_t rom_word;

    modport seq (
        output acc_clear, bias_load, mac_en, act_sel, layer2, neuron_done, neuron_idx
    );

    modport mac (
        input acc_clear, bias_load, mac_en, act_sel, layer2, neuron_done, neuron_idx,
        input rom_word
    );

endinterface

`default_nettype wire

/* logic/neuron_mac.sv */
`default_nettype none

module neuron_mac import dnn_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             frame_take,
    input  feat_t [N_IN-1:0] frame_feats,
    mac_if.mac               mac,
    output logic             score_valid,
    output acc_t             score,
    output class_t           score_idx
);

    localparam feat_t FEAT_MAX = {1'b0, {(FEAT_W - 1){1'b1}}};
    localparam acc_t ACC_SAT = acc_t'(FEAT_MAX);

    feat_t act_q [N_IN];
    feat_t hid_q [N_IN];
    acc_t acc_q;
    acc_t product;
    acc_t acc_next;
    feat_t relu_val;
    logic hid_done;
    logic hid_last;

    always_comb begin
        product = acc_t'(act_q[mac.act_sel]) * acc_t'(mac.rom_word);
        acc_next = acc_q + (product >>> FRAC_BITS);
        // ReLU, clipped to the largest Q8.8 value
        if (acc_next[ACC_W-1]) begin
            relu_val = '0;
        end else if (acc_next > ACC_SAT) begin
            relu_val = FEAT_MAX;
        end else begin
            relu_val = feat_t'(acc_next);
        end
    end

    assign hid_done = mac.neuron_done && !mac.layer2;
    assign hid_last = hid_done && (mac.neuron_idx == class_t'(N_HID - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q <= '0;
            score_valid <= 1'b0;
        end else begin
            if (mac.bias_load) begin
                acc_q <= acc_t'(mac.rom_word);
            end else if (mac.acc_clear) begin
                acc_q <= '0;
            end else if (mac.mac_en) begin
                acc_q <= acc_next;
            end
            score_valid <= mac.neuron_done && mac.layer2;
        end
    end

    // hidden results wait in hid_q until the whole layer is done
    always_ff @(posedge clk) begin
        if (hid_done) begin
            hid_q[mac.neuron_idx] <= relu_val;
        end
        if (frame_take) begin
            for (int i = 0; i < N_IN; i++) begin
                act_q[i] <= frame_feats[i];
            end
        end else if (hid_last) begin
            for (int i = 0; i < N_IN; i++) begin
                act_q[i] <= (class_t'(i) == mac.neuron_idx) ? relu_val : hid_q[i];
            end
        end
        if (mac.neuron_done && mac.layer2) begin
            score <= acc_next;
            score_idx <= mac.neuron_idx;
        end
    end

endmodule

`default_nettype wire

/* logic/weight_rom.sv */
`default_nettype none

module weight_rom import dnn_pkg::*; (
    input  logic      clk,
    input  rom_addr_t rom_addr,
    output weight_t   rom_word
);

    // hidden neurons first, then output neurons
    weight_t mem [ROM_DEPTH];

    initial begin
        $readmemh(ROM_FILE, mem);
    end

    always_ff @(posedge clk) begin
        rom_word <= mem[rom_addr];
    end

endmodule

`default_nettype wire

/* project.f */
logic/dnn_pkg.sv
logic/mac_if.sv
logic/frame_buffer.sv
logic/weight_rom.sv
logic/layer_sequencer.sv
logic/neuron_mac.sv
logic/argmax_unit.sv
logic/dnn_top.sv
tb/dnn_assertions.sv
tb/tb_dnn.sv

/* run.sh */
#!/bin/sh
# build and run the DNN testbench with Verilator from the project root

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter project root"
    exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_dnn -Mdir obj_dir -o tb_dnn_sim -f project.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_dnn_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0

/* tb/dnn_assertions.sv */
`default_nettype none

module dnn_assertions import dnn_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic in_credit,
    input logic out_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BEATS = N_IN / FEATS_PER_BEAT;

    // beats still allowed under the credit the sender holds
    int beats_left;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beats_left <= 0;
        end else if (in_credit) begin
            beats_left <= BEATS - (in_valid ? 1 : 0);
        end else if (in_valid) begin
            beats_left <= beats_left - 1;
        end
    end

    beat_needs_credit: assert property (
        @(posedge clk) disable iff (!rst_n) in_valid |-> (in_credit || beats_left > 0)
    ) else $error("in_valid seen without a credit");

    single_cycle_result: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |=> !out_valid
    ) else $error("out_valid high for two cycles in a row");

    no_credit_in_reset: assert property (
        @(posedge clk) !rst_n |-> !in_credit
    ) else $error("in_credit high during reset");

endmodule

bind dnn_top dnn_assertions dnn_assertions_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_credit (in_credit),
    .out_valid (out_valid)
);

`default_nettype wire

/* tb/tb_dnn.sv */
`default_nettype none

module tb_dnn import dnn_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned SEED = 32'haab7d07b;
    localparam int RESET_CYCLES = 8;
    localparam int TIMEOUT = 300;
    localparam int DRAIN_CYCLES = 64;
    localparam int N_FRAMES = 50;
    localparam int KIND_RANDOM = 0;
    localparam int KIND_NEGATIVE = 1;
    localparam int KIND_MAX = 2;

    typedef feat_t [N_IN-1:0] frame_t;

    logic clk = 1'b0;
    logic rst_n;
    logic in_valid;
    feat_t [FEATS_PER_BEAT-1:0] in_data;
    logic in_credit;
    logic out_valid;
    class_t out_class;

    weight_t rom [ROM_DEPTH];
    class_t expected_q [$];
    logic have_credit = 1'b0;
    logic timed_out = 1'b0;
    int results = 0;
    int checks = 0;
    int errors = 0;

    dnn_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_credit (in_credit),
        .out_valid (out_valid),
        .out_class (out_class)
    );

    always #10 clk = ~clk;

    task automatic check_class(input string name, input class_t got, input class_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("Timed out waiting for %s", what);
    endtask

    function automatic longint widen(input logic [15:0] v);
        return longint'(signed'(v));
    endfunction

    // reference network, straight from the Q8.8 rules
    function automatic class_t model_class(input frame_t f);
        feat_t hid [N_HID];
        longint acc;
        longint best;
        class_t best_idx;
        int base;
        best = 0;
        best_idx = '0;
        for (int n = 0; n < N_HID; n++) begin
            base = n * (N_IN + 1);
            acc = widen(rom[base]);
            for (int i = 0; i < N_IN; i++) begin
                acc += (widen(f[i]) * widen(rom[base + 1 + i])) >>> FRAC_BITS;
            end
            if (acc < 0) begin
                hid[n] = '0;
            end else if (acc > 32767) begin
                hid[n] = 16'sh7fff;
            end else begin
                hid[n] = feat_t'(acc);
            end
        end
        for (int o = 0; o < N_OUT; o++) begin
            base = N_HID * (N_IN + 1) + o * (N_HID + 1);
            acc = widen(rom[base]);
            for (int i = 0; i < N_HID; i++) begin
                acc += (widen(hid[i]) * widen(rom[base + 1 + i])) >>> FRAC_BITS;
            end
            // strictly greater, so a tie keeps the lower class
            if (o == 0 || acc > best) begin
                best = acc;
                best_idx = class_t'(o);
            end
        end
        return best_idx;
    endfunction

    function automatic frame_t make_frame(input int kind);
        frame_t f;
        for (int i = 0; i < N_IN; i++) begin
            case (kind)
                KIND_NEGATIVE: f[i] = feat_t'(32'h8000 + $urandom_range(0, 16383));
                KIND_MAX: f[i] = feat_t'(16'h7fff);
                default: f[i] = feat_t'($urandom_range(0, 4095) - 2048);
            endcase
        end
        return f;
    endfunction

    task automatic wait_credit();
        for (int c = 0; c < TIMEOUT; c++) begin
            @(negedge clk);
            if (in_credit) begin
                have_credit = 1'b1;
                break;
            end
        end
        if (!have_credit) begin
            note_timeout("a credit");
        end
    endtask

    // oldest features go in the first beat, lane 0 first
    task automatic send_frame(input frame_t f);
        for (int b = 0; b < N_IN / FEATS_PER_BEAT; b++) begin
            repeat ($urandom_range(0, 2)) @(negedge clk);
            for (int j = 0; j < FEATS_PER_BEAT; j++) begin
                in_data[j] = f[b * FEATS_PER_BEAT + j];
            end
            in_valid = 1'b1;
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic send_all(input int count, input int kind);
        frame_t f;
        for (int n = 0; n < count; n++) begin
            if (!have_credit) begin
                wait_credit();
            end
            if (!have_credit) begin
                break;
            end
            f = make_frame(kind);
            expected_q.push_back(model_class(f));
            send_frame(f);
            have_credit = 1'b0;
        end
        // pick up the credit for the frame just taken
        if (!timed_out) begin
            wait_credit();
        end
    endtask

    task automatic receive_all(input int count);
        logic got;
        results = 0;
        for (int n = 0; n < count; n++) begin
            got = 1'b0;
            for (int c = 0; c < TIMEOUT && !got; c++) begin
                @(negedge clk);
                got = out_valid;
            end
            if (!got) begin
                note_timeout("a classification result");
                break;
            end
            results++;
            check_class("out_class", out_class, expected_q.pop_front());
        end
    endtask

    task automatic run_frames(input string name, input int count, input int kind);
        int errors_before = errors;
        int extra = 0;
        fork
            send_all(count, kind);
            receive_all(count);
        join
        // no result may follow the last expected one
        for (int c = 0; c < DRAIN_CYCLES; c++) begin
            @(negedge clk);
            if (out_valid) begin
                extra++;
            end
        end
        check_count("results", results + extra, count);
        $display("%s: %0d frames, %0d errors", name, count, errors - errors_before);
    endtask

    task automatic test_reset();
        int credit_high = 0;
        int valid_high = 0;
        int extra = 0;
        int errors_before = errors;
        rst_n = 1'b0;
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(negedge clk);
            if (in_credit) credit_high++;
            if (out_valid) valid_high++;
        end
        rst_n = 1'b1;
        check_count("in_credit during reset", credit_high, 0);
        check_count("out_valid during reset", valid_high, 0);
        wait_credit();
        if (have_credit) begin
            for (int c = 0; c < 16; c++) begin
                @(negedge clk);
                if (in_credit) extra++;
            end
            check_count("credits after reset", 1 + extra, 1);
        end
        $display("reset: %0d errors", errors - errors_before);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        $readmemh("dnn_weights.hex", rom);
        test_reset();
        if (!timed_out) run_frames("single frame", 1, KIND_RANDOM);
        if (!timed_out) run_frames("stream", N_FRAMES, KIND_RANDOM);
        if (!timed_out) run_frames("relu clipping", 4, KIND_NEGATIVE);
        if (!timed_out) run_frames("saturation", 4, KIND_MAX);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
